// ==== include/axis_mux_defines.svh ====
// ******************************
// port count and field widths for the stream mux
// keep width must stay data width / 8
// ******************************
`ifndef AXIS_MUX_DEFINES_SVH
`define AXIS_MUX_DEFINES_SVH

// number of source ports
`define AXM_S_COUNT 4

// beat payload width in bits
`define AXM_DATA_WIDTH 32

// one keep bit per data byte
`define AXM_KEEP_WIDTH (`AXM_DATA_WIDTH / 8)

// log2 of the port count, carried on tid
`define AXM_ID_WIDTH 2

`endif

// ==== verilog/axis_mux_pkg.sv ====
// ******************************
// beat and index types shared by the mux blocks
// ******************************
`include "axis_mux_defines.svh"

package axis_mux_pkg;

    // index of a source port, also the output tid
    typedef logic [`AXM_ID_WIDTH-1:0] src_idx_t;

    // one stream beat
    // id is ignored on the inputs, the select stage fills it in
    typedef struct packed {
        logic [`AXM_DATA_WIDTH-1:0] data;
        logic [`AXM_KEEP_WIDTH-1:0] keep;
        logic                       last;
        logic                       user;
        src_idx_t                   id;
    } beat_t;

endpackage

// ==== verilog/stream_arbiter.sv ====
// ******************************
// round-robin packet arbiter, grant held until ack
// port count must fit in the index type
// ******************************
`timescale 1ns/1ps
`include "axis_mux_defines.svh"

module stream_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`AXM_S_COUNT-1:0]  request,
    input  logic                     ack,
    output logic                     grant_valid,
    output axis_mux_pkg::src_idx_t   grant_idx
);
    import axis_mux_pkg::*;

    // result of the rotated search
    src_idx_t next_idx;
    logic     next_found;

    // grant_idx keeps the last winner after the grant drops,
    // so it doubles as the round-robin pointer
    always_comb begin
        int pos;

        next_idx   = grant_idx;
        next_found = 1'b0;
        pos        = 0;
        // start one past the last winner and wrap around
        for (int i = 1; i <= `AXM_S_COUNT; i++) begin
            pos = (int'(grant_idx) + i) % `AXM_S_COUNT;
            if (!next_found && request[pos]) begin
                next_found = 1'b1;
                next_idx   = src_idx_t'(pos);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_idx   <= '0;
        end else if (grant_valid) begin
            // last beat of the packet taken, release
            if (ack) begin
                grant_valid <= 1'b0;
            end
        end else if (next_found) begin
            grant_valid <= 1'b1;
            grant_idx   <= next_idx;
        end
    end

endmodule

// ==== verilog/stream_select.sv ====
// ******************************
// beat mux toward the skid register
// ready goes back to the granted source only
// ******************************
`timescale 1ns/1ps
`include "axis_mux_defines.svh"

module stream_select (
    input  axis_mux_pkg::beat_t      s_beat [`AXM_S_COUNT],
    input  logic [`AXM_S_COUNT-1:0]  s_valid,
    output logic [`AXM_S_COUNT-1:0]  s_ready,
    input  logic                     grant_valid,
    input  axis_mux_pkg::src_idx_t   grant_idx,
    input  logic                     up_ready,
    output axis_mux_pkg::beat_t      sel_beat,
    output logic                     sel_valid,
    output logic                     ack,
    output logic [`AXM_S_COUNT-1:0]  request
);
    import axis_mux_pkg::*;

    logic [`AXM_S_COUNT-1:0] grant_onehot;
    beat_t                   cur_beat;

    // one-hot copy of the grant, zero while nothing is granted
    assign grant_onehot = grant_valid ?
                          ({{(`AXM_S_COUNT-1){1'b0}}, 1'b1} << grant_idx) : '0;

    assign cur_beat = s_beat[grant_idx];

    // tag the beat with its source
    always_comb begin
        sel_beat    = cur_beat;
        sel_beat.id = grant_idx;
    end

    assign sel_valid = grant_valid & s_valid[grant_idx];
    assign s_ready   = up_ready ? grant_onehot : '0;

    // end of packet leaves the granted source
    assign ack = sel_valid & up_ready & cur_beat.last;

    // the holder of the grant does not compete again
    assign request = s_valid & ~grant_onehot;

endmodule

// ==== verilog/skid_register.sv ====
// ******************************
// two-entry output register, full rate
// up_ready is registered, one beat of slack
// ******************************
`timescale 1ns/1ps

module skid_register (
    input  logic                 clk,
    input  logic                 rst,
    input  axis_mux_pkg::beat_t  up_beat,
    input  logic                 up_valid,
    output logic                 up_ready,
    output axis_mux_pkg::beat_t  m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);
    import axis_mux_pkg::*;

    // output entry and temp entry
    beat_t out_beat;
    beat_t tmp_beat;
    logic  out_valid;
    logic  tmp_valid;

    logic out_valid_next;
    logic tmp_valid_next;
    logic up_ready_early;
    logic up_xfer;

    // datapath moves
    logic in_to_out;
    logic in_to_tmp;
    logic tmp_to_out;

    assign up_xfer = up_valid & up_ready;

    // ready next cycle unless the temp entry could fill
    assign up_ready_early = m_ready | (~tmp_valid & (~out_valid | ~up_xfer));

    always_comb begin
        out_valid_next = out_valid;
        tmp_valid_next = tmp_valid;
        in_to_out      = 1'b0;
        in_to_tmp      = 1'b0;
        tmp_to_out     = 1'b0;

        if (up_ready) begin
            if (m_ready || !out_valid) begin
                // output free or draining
                out_valid_next = up_valid;
                in_to_out      = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_next = up_valid;
                in_to_tmp      = 1'b1;
            end
        end else if (m_ready) begin
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
            up_ready  <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
            up_ready  <= up_ready_early;
        end
    end

    // payload entries
    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_beat <= up_beat;
        end else if (tmp_to_out) begin
            out_beat <= tmp_beat;
        end
        if (in_to_tmp) begin
            tmp_beat <= up_beat;
        end
    end

    assign m_beat  = out_beat;
    assign m_valid = out_valid;

endmodule

// ==== verilog/axis_arb_mux.sv ====
// ******************************
// 4-to-1 packet mux, round robin
// tid on the output names the source
// ******************************
`timescale 1ns/1ps
`include "axis_mux_defines.svh"

module axis_arb_mux (
    input  logic                     clk,
    input  logic                     rst,
    input  axis_mux_pkg::beat_t      s_beat [`AXM_S_COUNT],
    input  logic [`AXM_S_COUNT-1:0]  s_valid,
    output logic [`AXM_S_COUNT-1:0]  s_ready,
    output axis_mux_pkg::beat_t      m_beat,
    output logic                     m_valid,
    input  logic                     m_ready
);
    import axis_mux_pkg::*;

    logic [`AXM_S_COUNT-1:0] request;
    logic                    ack;
    logic                    grant_valid;
    src_idx_t                grant_idx;
    beat_t                   sel_beat;
    logic                    sel_valid;
    logic                    up_ready;

    stream_arbiter i_stream_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .ack         (ack),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    stream_select i_stream_select (
        .s_beat      (s_beat),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx),
        .up_ready    (up_ready),
        .sel_beat    (sel_beat),
        .sel_valid   (sel_valid),
        .ack         (ack),
        .request     (request)
    );

    skid_register i_skid_register (
        .clk      (clk),
        .rst      (rst),
        .up_beat  (sel_beat),
        .up_valid (sel_valid),
        .up_ready (up_ready),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

endmodule

// ==== verif/tb_clock.sv ====
// ******************************
// 4 ns clock, rst high for 4 edges
// ******************************
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release 1 ns after the fourth edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== verif/axis_arb_mux_sva.sv ====
// ******************************
// handshake and packet checks on the mux
// bound into axis_arb_mux
// ******************************
`timescale 1ns/1ps
`include "axis_mux_defines.svh"

module axis_arb_mux_sva (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`AXM_S_COUNT-1:0]  s_ready,
    input  axis_mux_pkg::beat_t      m_beat,
    input  logic                     m_valid,
    input  logic                     m_ready
);
    import axis_mux_pkg::*;

    // failed assertions so far, summed into the final count
    int failures = 0;

    // packet currently open on the output
    logic     pkt_open;
    src_idx_t pkt_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_open <= 1'b0;
            pkt_id   <= '0;
        end else if (m_valid && m_ready) begin
            pkt_open <= !m_beat.last;
            pkt_id   <= m_beat.id;
        end
    end

    // quiet during reset and in the first cycle after it
    reset_quiet: assert property (@(posedge clk)
        rst |=> (!m_valid && (s_ready == '0)))
    else begin
        $error("m_valid or s_ready high during or right after reset");
        failures++;
    end

    // an open packet finishes before another source shows up
    no_interleave: assert property (@(posedge clk) disable iff (rst)
        (m_valid && m_ready && pkt_open) |-> (m_beat.id == pkt_id))
    else begin
        $error("output beat from another source inside an open packet");
        failures++;
    end

    // stalled output holds its beat
    stall_stable: assert property (@(posedge clk) disable iff (rst)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else begin
        $error("output beat changed or vanished while stalled");
        failures++;
    end

    one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_ready))
    else begin
        $error("s_ready high on more than one source");
        failures++;
    end

endmodule

bind axis_arb_mux axis_arb_mux_sva i_axis_arb_mux_sva (
    .clk     (clk),
    .rst     (rst),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
);

// ==== verif/axis_arb_mux_tb.sv ====
// ******************************
// random packet traffic on all sources
// checks through the scoreboard and bound assertions
// ******************************
`timescale 1ns/1ps
`include "axis_mux_defines.svh"

module axis_arb_mux_tb;
    import axis_mux_pkg::*;

    localparam int n_src = `AXM_S_COUNT;
    // about four times the ~500 cycles the five tests take together
    localparam int max_cycles = 2000;

    logic             clk;
    logic             rst;
    beat_t            s_beat [n_src];
    logic [n_src-1:0] s_valid;
    logic [n_src-1:0] s_ready;
    beat_t            m_beat;
    logic             m_valid;
    logic             m_ready;

    // beats waiting to be offered, per source
    beat_t tx_q [n_src][$];
    // beats accepted from a source and not yet seen on the output
    beat_t sent_q [n_src][$];

    logic [n_src-1:0] src_fire;
    // rst as seen at the last rising edge
    logic             rst_at_edge;
    int               ready_pct;
    int               gap_pct;
    logic             rr_check;
    logic             rr_have_prev;
    src_idx_t         rr_prev;
    int               errors;
    int               beats_checked;
    int               cycle_count;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    axis_arb_mux i_axis_arb_mux (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    function automatic int total_errors();
        return errors + i_axis_arb_mux.i_axis_arb_mux_sva.failures;
    endfunction

    // one packet of random beats with a junk id field
    task automatic queue_packet(input int src, input int len);
        beat_t       b;
        logic [31:0] rnd;
        for (int k = 0; k < len; k++) begin
            rnd    = $urandom();
            b.data = $urandom();
            b.keep = rnd[`AXM_KEEP_WIDTH-1:0];
            b.user = rnd[8];
            b.id   = rnd[`AXM_ID_WIDTH+15:16];
            b.last = (k == len - 1);
            tx_q[src].push_back(b);
        end
    endtask

    task automatic record_source_beat(input int src);
        beat_t b;
        b    = s_beat[src];
        b.id = src_idx_t'(src);
        sent_q[src].push_back(b);
    endtask

    task automatic check_output_beat();
        beat_t exp_beat;
        int    idx;
        idx = int'(m_beat.id);
        if (sent_q[idx].size() == 0) begin
            $display("extra beat at %0t on tid %0d, nothing pending from that source",
                     $time, idx);
            errors++;
        end else begin
            exp_beat = sent_q[idx].pop_front();
            beats_checked++;
            assert (m_beat == exp_beat) else begin
                $display("mismatch at %0t: tid %0d beat %h, expected %h",
                         $time, idx, m_beat, exp_beat);
                errors++;
            end
        end
        // packets rotate through the sources
        if (rr_check && m_beat.last) begin
            if (rr_have_prev) begin
                assert (m_beat.id == src_idx_t'((int'(rr_prev) + 1) % n_src)) else begin
                    $display("mismatch at %0t: packet tid %0d after tid %0d",
                             $time, m_beat.id, rr_prev);
                    errors++;
                end
            end
            rr_prev      = m_beat.id;
            rr_have_prev = 1'b1;
        end
    endtask

    // sources idle, queues empty and output register empty
    task automatic wait_drained();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = (s_valid != '0) || m_valid;
            for (int i = 0; i < n_src; i++) begin
                if (tx_q[i].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        @(negedge clk);
    endtask

    task automatic check_all_delivered();
        for (int i = 0; i < n_src; i++) begin
            assert (sent_q[i].size() == 0) else begin
                $display("%0d beats accepted from source %0d never reached the output",
                         sent_q[i].size(), i);
                errors++;
                sent_q[i].delete();
            end
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: done, %0d beats checked, %0d errors",
                 num, name, beats_checked, total_errors());
    endtask

    // handshakes sampled mid cycle complete at the next edge
    always @(negedge clk) begin
        for (int i = 0; i < n_src; i++) begin
            src_fire[i] = s_valid[i] & s_ready[i];
            if (src_fire[i]) begin
                record_source_beat(i);
            end
        end
        if (m_valid && m_ready) begin
            check_output_beat();
        end
    end

    // source and sink drive 1 ns after the edge
    always @(posedge clk) begin
        rst_at_edge = rst;
        #1;
        if (rst_at_edge) begin
            s_valid = '0;
            m_ready = 1'b0;
        end else begin
            for (int i = 0; i < n_src; i++) begin
                if (src_fire[i]) begin
                    s_valid[i] = 1'b0;
                end
                if (!s_valid[i] && tx_q[i].size() > 0 &&
                    int'($urandom_range(99)) >= gap_pct) begin
                    s_beat[i]  = tx_q[i].pop_front();
                    s_valid[i] = 1'b1;
                end
            end
            m_ready = (int'($urandom_range(99)) < ready_pct);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int total;
        void'($urandom(75713));
        s_valid       = '0;
        m_ready       = 1'b0;
        src_fire      = '0;
        ready_pct     = 100;
        gap_pct       = 0;
        rr_check      = 1'b0;
        rr_have_prev  = 1'b0;
        rr_prev       = '0;
        errors        = 0;
        beats_checked = 0;
        cycle_count   = 0;
        for (int i = 0; i < n_src; i++) begin
            s_beat[i] = '0;
        end

        // reset values are checked by a bound assertion
        @(negedge rst);
        @(posedge clk);
        @(negedge clk);
        report_test(1, "reset");

        queue_packet(2, 5);
        wait_drained();
        check_all_delivered();
        report_test(2, "single source");

        // all sources with random lengths and gaps
        gap_pct = 30;
        for (int p = 0; p < 4; p++) begin
            for (int s = 0; s < n_src; s++) begin
                queue_packet(s, int'($urandom_range(7)) + 1);
            end
        end
        wait_drained();
        check_all_delivered();
        report_test(3, "no interleave");

        // every source requesting without a break
        gap_pct      = 0;
        rr_check     = 1'b1;
        rr_have_prev = 1'b0;
        for (int p = 0; p < 3; p++) begin
            for (int s = 0; s < n_src; s++) begin
                queue_packet(s, int'($urandom_range(3)) + 1);
            end
        end
        wait_drained();
        rr_check = 1'b0;
        check_all_delivered();
        report_test(4, "round robin");

        ready_pct = 50;
        gap_pct   = 20;
        for (int p = 0; p < 4; p++) begin
            for (int s = 0; s < n_src; s++) begin
                queue_packet(s, int'($urandom_range(7)) + 1);
            end
        end
        wait_drained();
        check_all_delivered();
        report_test(5, "back-pressure");

        total = total_errors();
        $display("tests 5, beats checked %0d, errors %0d", beats_checked, total);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/axis_mux_pkg.sv
verilog/stream_arbiter.sv
verilog/stream_select.sv
verilog/skid_register.sv
verilog/axis_arb_mux.sv
verif/tb_clock.sv
verif/axis_arb_mux_sva.sv
verif/axis_arb_mux_tb.sv

// ==== Makefile ====
# Verilator build and run of the stream mux testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f sim.f --top-module axis_arb_mux_tb \
		-Mdir obj_dir -o axis_arb_mux_sim
	./obj_dir/axis_arb_mux_sim +verilator+error+limit+100 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
